// File: compile.f
rtl/copy_types_pkg.sv
rtl/copy_csr_pkg.sv
rtl/copy_ctrl.sv
rtl/copy_rd_engine.sv
rtl/copy_line_buffer.sv
rtl/copy_wr_engine.sv
rtl/copy_engine_top.sv
test/copy_host_mem_model.sv
test/copy_engine_assert.sv
test/tb_copy_engine.sv

// File: rtl/copy_csr_pkg.sv
`default_nettype none
// ==========================================================
// copy engine register map and control state encoding
// ==========================================================

package copy_csr_pkg;

    import copy_types_pkg::*;

    // register byte offsets, one 64-bit word apart
    localparam csr_addr_t CSR_SRC    = 8'h00;
    localparam csr_addr_t CSR_DST    = 8'h08;
    localparam csr_addr_t CSR_LEN    = 8'h10;
    localparam csr_addr_t CSR_CTRL   = 8'h18;
    localparam csr_addr_t CSR_STATUS = 8'h20;

    // writing a one here launches a job when the engine is idle
    localparam int CTRL_START = 0;

    // status word layout, the line count sits in the upper half
    localparam int STATUS_BUSY      = 0;
    localparam int STATUS_DONE      = 1;
    localparam int STATUS_COUNT_LSB = 32;

    // job state, FINISH holds done until software starts again
    typedef enum logic [1:0] {IDLE, RUN, FINISH} copy_state_t;

endpackage

`default_nettype wire

// File: rtl/copy_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
// ==========================================================
// copy control, CSR register file and the job state machine
// ==========================================================

module copy_ctrl
    import copy_types_pkg::*;
    import copy_csr_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      csr_wr,
    input  logic      csr_rd,
    input  csr_addr_t csr_addr,
    input  csr_data_t csr_wdata,
    output csr_data_t csr_rdata,
    output logic      csr_rvalid,
    output logic      job_start,
    output addr_t     job_src,
    output addr_t     job_dst,
    output len_t      job_len,
    input  len_t      lines_done,
    input  logic      wr_done
);

    addr_t       src_q;
    addr_t       dst_q;
    len_t        len_q;
    copy_state_t state_q;
    copy_state_t state_d;
    logic        start_req;
    csr_data_t   status;

    // a start in RUN is dropped, the running job keeps its registers
    assign start_req = csr_wr && (csr_addr == CSR_CTRL) &&
                       csr_wdata[CTRL_START] && (state_q != RUN);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE, FINISH: if (start_req) state_d = RUN;
            // the write engine reports the last ack, done follows a cycle later
            RUN:          if (wr_done) state_d = FINISH;
            default:      state_d = IDLE;
        endcase
    end

    // status word, busy and done come straight from the state
    always_comb begin
        status = '0;
        status[STATUS_BUSY] = (state_q == RUN);
        status[STATUS_DONE] = (state_q == FINISH);
        status[STATUS_COUNT_LSB +: $bits(len_t)] = lines_done;
    end

    // ==========================================================
    // register writes and state
    // ==========================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= IDLE;
            job_start  <= 1'b0;
            csr_rvalid <= 1'b0;
            src_q      <= '0;
            dst_q      <= '0;
            len_q      <= '0;
        end else begin
            state_q    <= state_d;
            job_start  <= start_req;
            // read data always follows the strobe by exactly one cycle
            csr_rvalid <= csr_rd;
            if (csr_wr && (csr_addr == CSR_SRC)) src_q <= csr_wdata[$bits(addr_t)-1:0];
            if (csr_wr && (csr_addr == CSR_DST)) dst_q <= csr_wdata[$bits(addr_t)-1:0];
            if (csr_wr && (csr_addr == CSR_LEN)) len_q <= csr_wdata[$bits(len_t)-1:0];
        end
    end

    // job snapshot is taken on the start edge so later CSR writes leave it alone
    always_ff @(posedge clk) begin
        if (start_req) begin
            job_src <= src_q;
            job_dst <= dst_q;
            job_len <= len_q;
        end
        case (csr_addr)
            CSR_SRC:    csr_rdata <= csr_data_t'(src_q);
            CSR_DST:    csr_rdata <= csr_data_t'(dst_q);
            CSR_LEN:    csr_rdata <= csr_data_t'(len_q);
            CSR_STATUS: csr_rdata <= status;
            // control reads back as zero, as do unmapped offsets
            default:    csr_rdata <= '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/copy_engine_top.sv
`timescale 1ns/1ps
`default_nettype none
// ==========================================================
// copy engine top, control and datapath tied together
// ==========================================================

module copy_engine_top
    import copy_types_pkg::*;
#(
    parameter int FIFO_DEPTH = 4,
    parameter int WR_CREDITS = 2
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      csr_wr,
    input  logic      csr_rd,
    input  csr_addr_t csr_addr,
    input  csr_data_t csr_wdata,
    output csr_data_t csr_rdata,
    output logic      csr_rvalid,
    output logic      rd_req_valid,
    output addr_t     rd_req_addr,
    input  logic      rd_rsp_valid,
    input  line_t     rd_rsp_data,
    output logic      wr_req_valid,
    output addr_t     wr_req_addr,
    output line_t     wr_req_data,
    input  logic      wr_credit,
    input  logic      wr_ack
);

    logic  job_start;
    addr_t job_src;
    addr_t job_dst;
    len_t  job_len;
    len_t  lines_done;
    logic  wr_done;
    logic  buf_pop;
    logic  buf_empty;
    line_t buf_data;
    logic  pop;

    copy_ctrl u_ctrl (
        .clk, .arst_n, .csr_wr, .csr_rd, .csr_addr, .csr_wdata, .csr_rdata, .csr_rvalid,
        .job_start, .job_src, .job_dst, .job_len, .lines_done, .wr_done
    );

    // the reader and the buffer must agree on depth for the credit rule to hold
    copy_rd_engine #(.FIFO_DEPTH(FIFO_DEPTH)) u_rd (
        .clk, .arst_n, .job_start, .job_src, .job_len, .buf_pop, .rd_req_valid, .rd_req_addr
    );

    copy_line_buffer #(.FIFO_DEPTH(FIFO_DEPTH)) u_buf (
        .clk, .arst_n, .rd_rsp_valid, .rd_rsp_data, .pop, .buf_empty, .buf_data, .buf_pop
    );

    // write credits match what the host side grants at reset
    copy_wr_engine #(.WR_CREDITS(WR_CREDITS)) u_wr (
        .clk, .arst_n, .job_start, .job_dst, .job_len, .buf_empty, .buf_data, .pop,
        .wr_req_valid, .wr_req_addr, .wr_req_data, .wr_credit, .wr_ack, .lines_done, .wr_done
    );

endmodule

`default_nettype wire

// File: rtl/copy_line_buffer.sv
`timescale 1ns/1ps
`default_nettype none
// ==========================================================
// copy line buffer, read responses queued for the writer
// ==========================================================

module copy_line_buffer
    import copy_types_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  rd_rsp_valid,
    input  line_t rd_rsp_data,
    input  logic  pop,
    output logic  buf_empty,
    output line_t buf_data,
    output logic  buf_pop
);

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    line_t         mem [FIFO_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          take;

    assign buf_empty = (count == '0);
    assign buf_data  = mem[rd_ptr];
    // a pop on an empty buffer is not a pop, so it earns no credit
    assign take      = pop && !buf_empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            buf_pop <= 1'b0;
        end else begin
            // pointers wrap at the depth, which need not be a power of two
            if (rd_rsp_valid) wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (take) rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count   <= count + CW'(rd_rsp_valid) - CW'(take);
            buf_pop <= take;
        end
    end

    // the read credit rule keeps this from writing into a full buffer
    always_ff @(posedge clk) begin
        if (rd_rsp_valid) mem[wr_ptr] <= rd_rsp_data;
    end

endmodule

`default_nettype wire

// File: rtl/copy_rd_engine.sv
`timescale 1ns/1ps
`default_nettype none
// ==========================================================
// copy read engine, line reads issued against buffer credits
// ==========================================================

module copy_rd_engine
    import copy_types_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  job_start,
    input  addr_t job_src,
    input  len_t  job_len,
    input  logic  buf_pop,
    output logic  rd_req_valid,
    output addr_t rd_req_addr
);

    localparam int CW = $clog2(FIFO_DEPTH + 1);

    len_t          remain_q;
    addr_t         addr_q;
    logic [CW-1:0] credit_q;
    logic          issue;

    // one credit per buffer slot, so every response has a place to land
    assign issue        = (remain_q != '0) && (credit_q != '0);
    assign rd_req_valid = issue;
    assign rd_req_addr  = addr_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            remain_q <= '0;
            addr_q   <= '0;
            credit_q <= CW'(FIFO_DEPTH);
        end else begin
            if (job_start) begin
                remain_q <= job_len;
                addr_q   <= job_src;
            end else if (issue) begin
                remain_q <= remain_q - 1'b1;
                addr_q   <= addr_q + addr_t'(LINE_BYTES);
            end
            // spend on issue and regain on pop, both may happen together
            credit_q <= credit_q + CW'(buf_pop) - CW'(issue);
        end
    end

endmodule

`default_nettype wire

// File: rtl/copy_types_pkg.sv
`default_nettype none
// ==========================================================
// copy engine types shared by the control and datapath blocks
// ==========================================================

package copy_types_pkg;

    // host byte address as seen on the memory request ports
    typedef logic [47:0] addr_t;

    // one line of copied data, the unit of every memory transfer
    typedef logic [63:0] line_t;

    // a count of lines, used for job length and completion count
    typedef logic [15:0] len_t;

    // one word on the 64-bit CSR port
    typedef logic [63:0] csr_data_t;

    // byte offset into the CSR space
    typedef logic [7:0]  csr_addr_t;

    // the address advances by one line of bytes per request
    localparam int LINE_BYTES = 8;

endpackage

`default_nettype wire

// File: rtl/copy_wr_engine.sv
`timescale 1ns/1ps
`default_nettype none
// ==========================================================
// copy write engine, buffered lines written under host credits
// ==========================================================

module copy_wr_engine
    import copy_types_pkg::*;
#(
    parameter int WR_CREDITS = 2
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  job_start,
    input  addr_t job_dst,
    input  len_t  job_len,
    input  logic  buf_empty,
    input  line_t buf_data,
    output logic  pop,
    output logic  wr_req_valid,
    output addr_t wr_req_addr,
    output line_t wr_req_data,
    input  logic  wr_credit,
    input  logic  wr_ack,
    output len_t  lines_done,
    output logic  wr_done
);

    localparam int CW = $clog2(WR_CREDITS + 1);

    addr_t         addr_q;
    logic [CW-1:0] credit_q;

    // a line leaves the buffer only when the host has room for it
    assign pop          = !buf_empty && (credit_q != '0);
    assign wr_req_valid = pop;
    assign wr_req_addr  = addr_q;
    assign wr_req_data  = buf_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            addr_q     <= '0;
            credit_q   <= CW'(WR_CREDITS);
            lines_done <= '0;
            wr_done    <= 1'b0;
        end else begin
            if (job_start) addr_q <= job_dst;
            else if (pop)  addr_q <= addr_q + addr_t'(LINE_BYTES);
            credit_q <= credit_q + CW'(wr_credit) - CW'(pop);
            // completion counts acks, not requests, so done means data landed
            if (job_start)   lines_done <= '0;
            else if (wr_ack) lines_done <= lines_done + 1'b1;
            // an empty job finishes right at start with no traffic
            wr_done <= (job_start && (job_len == '0)) ||
                       (!job_start && wr_ack && (lines_done + 1'b1 == job_len));
        end
    end

endmodule

`default_nettype wire

// File: test/copy_engine_assert.sv
`timescale 1ns/1ps
`default_nettype none
// ==========================================================
// copy engine checks on credit use and request timing
// ==========================================================

module copy_engine_assert #(
    parameter int WR_CREDITS = 2
) (
    input logic clk,
    input logic arst_n,
    input logic job_start,
    input logic wr_done,
    input logic rd_req_valid,
    input logic rd_rsp_valid,
    input logic wr_req_valid,
    input logic wr_ack
);

    int   wr_outst;
    int   rd_pend;
    logic busy;
    int   failures = 0;

    // in-flight counts and a busy flag that spans start to the last ack
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_outst <= 0;
            rd_pend  <= 0;
            busy     <= 1'b0;
        end else begin
            wr_outst <= wr_outst + int'(wr_req_valid) - int'(wr_ack);
            rd_pend  <= rd_pend + int'(rd_req_valid) - int'(rd_rsp_valid);
            if (job_start) busy <= 1'b1;
            else if (wr_done) busy <= 1'b0;
        end
    end

    a_wr_credit: assert property (@(posedge clk) disable iff (!arst_n)
        wr_outst <= WR_CREDITS)
        else begin
            failures++;
            $error("writes outstanding exceed the write credit count");
        end

    a_rsp_pending: assert property (@(posedge clk) disable iff (!arst_n)
        rd_rsp_valid |-> rd_pend > 0)
        else begin
            failures++;
            $error("read response arrived with no read pending");
        end

    a_req_busy: assert property (@(posedge clk) disable iff (!arst_n)
        (rd_req_valid || wr_req_valid) |-> busy)
        else begin
            failures++;
            $error("memory request issued while no job is running");
        end

endmodule

bind copy_engine_top copy_engine_assert #(.WR_CREDITS(WR_CREDITS)) u_assert (
    .clk, .arst_n, .job_start, .wr_done, .rd_req_valid, .rd_rsp_valid, .wr_req_valid, .wr_ack
);

`default_nettype wire

// File: test/copy_host_mem_model.sv
`timescale 1ns/1ps
`default_nettype none
// ==========================================================
// host memory model, in-order reads and acked writes
// ==========================================================

module copy_host_mem_model
    import copy_types_pkg::*;
#(
    parameter int WR_CREDITS = 2
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  random_delay,
    input  logic  rd_req_valid,
    input  addr_t rd_req_addr,
    output logic  rd_rsp_valid,
    output line_t rd_rsp_data,
    input  logic  wr_req_valid,
    input  addr_t wr_req_addr,
    input  line_t wr_req_data,
    output logic  wr_credit,
    output logic  wr_ack
);

    // reads wait here in request order until the model lets them go
    line_t rsp_q [$];
    // every write lands in these logs, in arrival order
    addr_t wr_addr_log [$];
    line_t wr_data_log [$];
    int    rd_count;
    int    ack_pend;
    int    overruns;

    // the preloaded contents, each line a function of its full address
    function automatic line_t fill_pattern(addr_t a);
        return {a[15:0], a} ^ 64'h5a3c_96e1_0f87_d24b;
    endfunction

    // under random delay a waiting response goes out about one cycle in three
    function automatic logic go_now();
        return !random_delay || ($urandom_range(2) == 0);
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_rsp_valid <= 1'b0;
            rd_rsp_data  <= '0;
            wr_ack       <= 1'b0;
            wr_credit    <= 1'b0;
            rsp_q.delete();
            rd_count = 0;
            ack_pend = 0;
            overruns = 0;
        end else begin
            rd_rsp_valid <= 1'b0;
            wr_ack       <= 1'b0;
            wr_credit    <= 1'b0;
            if (rsp_q.size() != 0 && go_now()) begin
                rd_rsp_valid <= 1'b1;
                rd_rsp_data  <= rsp_q.pop_front();
            end
            // the credit goes back together with the ack of the same write
            if (ack_pend != 0 && go_now()) begin
                wr_ack    <= 1'b1;
                wr_credit <= 1'b1;
                ack_pend--;
            end
            if (rd_req_valid) begin
                rsp_q.push_back(fill_pattern(rd_req_addr));
                rd_count++;
            end
            if (wr_req_valid) begin
                wr_addr_log.push_back(wr_req_addr);
                wr_data_log.push_back(wr_req_data);
                ack_pend++;
                // more writes in flight than granted credits means the engine overspent
                if (ack_pend > WR_CREDITS) overruns++;
            end
        end
    end

endmodule

`default_nettype wire

// File: test/tb_copy_engine.sv
`timescale 1ns/1ps
`default_nettype none
// ==========================================================
// copy engine testbench that runs a job table against a host model
// ==========================================================

module tb_copy_engine
    import copy_types_pkg::*;
    import copy_csr_pkg::*;
();

    localparam int FIFO_DEPTH  = 4;
    localparam int WR_CREDITS  = 2;
    localparam int NUM_JOBS    = 6;
    // a generous budget per job on top of the reset cycles
    localparam int CYCLE_LIMIT = 8 + 200 * NUM_JOBS;

    // one row per job where restart writes a second start while the job runs
    typedef struct {
        addr_t src;
        addr_t dst;
        len_t  len;
        bit    rnd;
        bit    restart;
    } job_t;

    logic      clk, arst_n, csr_wr, csr_rd, csr_rvalid, random_delay;
    csr_addr_t csr_addr;
    csr_data_t csr_wdata, csr_rdata;
    logic      rd_req_valid, rd_rsp_valid, wr_req_valid, wr_credit, wr_ack;
    addr_t     rd_req_addr, wr_req_addr;
    line_t     rd_rsp_data, wr_req_data;
    job_t      jobs [NUM_JOBS];
    int        errors = 0;
    int        cycles = 0;

    copy_engine_top #(.FIFO_DEPTH(FIFO_DEPTH), .WR_CREDITS(WR_CREDITS)) DUT (.*);
    copy_host_mem_model #(.WR_CREDITS(WR_CREDITS)) model (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // hard stop when a job never reports done
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, jobs still not finished after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    task automatic compare_value(input string name, input csr_data_t exp, input csr_data_t act);
        assert (act == exp) else begin
            errors++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic csr_write(input csr_addr_t a, input csr_data_t d);
        @(posedge clk);
        csr_wr    <= 1'b1;
        csr_addr  <= a;
        csr_wdata <= d;
        @(posedge clk);
        csr_wr <= 1'b0;
    endtask

    // read data must show up exactly one cycle after the strobe
    task automatic csr_read(input csr_addr_t a, output csr_data_t d);
        @(posedge clk);
        csr_rd   <= 1'b1;
        csr_addr <= a;
        @(negedge clk);
        assert (!csr_rvalid) else begin
            errors++;
            $display("csr_rvalid came in the same cycle as csr_rd at %0t", $time);
        end
        @(posedge clk);
        csr_rd <= 1'b0;
        @(negedge clk);
        assert (csr_rvalid) else begin
            errors++;
            $display("csr_rvalid missing one cycle after csr_rd at %0t", $time);
        end
        d = csr_rdata;
    endtask

    task automatic run_job(input job_t j);
        csr_data_t rd;
        csr_data_t st;
        model.rd_count = 0;
        model.wr_addr_log.delete();
        model.wr_data_log.delete();
        @(posedge clk);
        random_delay <= j.rnd;
        csr_write(CSR_SRC, csr_data_t'(j.src));
        csr_write(CSR_DST, csr_data_t'(j.dst));
        csr_write(CSR_LEN, csr_data_t'(j.len));
        csr_read(CSR_SRC, rd);
        compare_value("csr_rdata CSR_SRC", csr_data_t'(j.src), rd);
        csr_read(CSR_DST, rd);
        compare_value("csr_rdata CSR_DST", csr_data_t'(j.dst), rd);
        csr_read(CSR_LEN, rd);
        compare_value("csr_rdata CSR_LEN", csr_data_t'(j.len), rd);
        csr_read(CSR_CTRL, rd);
        compare_value("csr_rdata CSR_CTRL", '0, rd);
        csr_write(CSR_CTRL, csr_data_t'(1) << CTRL_START);
        // a second job aimed elsewhere that the running engine must drop
        if (j.restart) begin
            csr_write(CSR_SRC, csr_data_t'(j.src + 48'h10_0000));
            csr_write(CSR_DST, csr_data_t'(j.dst + 48'h40_0000));
            csr_write(CSR_LEN, csr_data_t'(4));
            csr_write(CSR_CTRL, csr_data_t'(1) << CTRL_START);
        end
        do begin
            csr_read(CSR_STATUS, st);
        end while (!st[STATUS_DONE]);
        compare_value("status busy", '0, csr_data_t'(st[STATUS_BUSY]));
        compare_value("status count", csr_data_t'(j.len), csr_data_t'(st[STATUS_COUNT_LSB +: 16]));
        compare_value("read request count", csr_data_t'(j.len), csr_data_t'(model.rd_count));
        compare_value("write count", csr_data_t'(j.len), csr_data_t'(model.wr_addr_log.size()));
        // destination line k must hold the pattern of source line k
        for (int k = 0; k < model.wr_addr_log.size(); k++) begin
            compare_value("wr_req_addr", csr_data_t'(j.dst + addr_t'(k * LINE_BYTES)),
                          csr_data_t'(model.wr_addr_log[k]));
            compare_value("wr_req_data", model.fill_pattern(j.src + addr_t'(k * LINE_BYTES)),
                          model.wr_data_log[k]);
        end
    endtask

    initial begin
        void'($urandom(96));
        arst_n       = 1'b0;
        csr_wr       = 1'b0;
        csr_rd       = 1'b0;
        csr_addr     = '0;
        csr_wdata    = '0;
        random_delay = 1'b0;
        // plain, back-pressure, zero length, restart mid-job, back-pressure, high address
        jobs[0] = '{48'h0000_0000_1000, 48'h0000_0000_8000, 16'd5,  1'b0, 1'b0};
        jobs[1] = '{48'h0000_0012_3400, 48'h0000_00ab_c000, 16'd11, 1'b1, 1'b0};
        jobs[2] = '{48'h0000_0000_2000, 48'h0000_0000_9000, 16'd0,  1'b0, 1'b0};
        jobs[3] = '{48'h007f_0000_0040, 48'h0003_0000_0000, 16'd12, 1'b1, 1'b1};
        jobs[4] = '{48'h0000_0000_5000, 48'h0000_0000_a000, 16'd9,  1'b1, 1'b0};
        jobs[5] = '{48'hffff_0000_1000, 48'h0000_4000_2000, 16'd3,  1'b0, 1'b0};
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        foreach (jobs[n]) run_job(jobs[n]);
        assert (model.overruns == 0) else begin
            errors++;
            $display("host model saw more writes in flight than write credits");
        end
        assert (DUT.u_assert.failures == 0) else begin
            errors++;
            $display("bound credit and request assertions failed %0d times",
                     DUT.u_assert.failures);
        end
        $display("run finished with %0d errors", errors);
        if (errors == 0) $display("No errors");
        else $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
